//--- all.f
+incdir+verif
hw/poly_mul_pkg.sv
hw/clmul_limb.sv
hw/limb_scheduler.sv
hw/product_fifo.sv
hw/product_accumulator.sv
hw/poly_mul_top.sv
verif/poly_mul_tb.sv

//--- hw/clmul_limb.sv
`timescale 1ns/1ns
`default_nettype none

module clmul_limb #(
    parameter int LIMB_W = poly_mul_pkg::LIMB_W
) (
    input  wire logic [LIMB_W-1:0]   x,
    input  wire logic [LIMB_W-1:0]   y,
    output logic      [2*LIMB_W-2:0] p
);

    localparam int P_W = 2 * LIMB_W - 1;

    // one shifted row of AND terms per bit of y
    logic [P_W-1:0] rows [LIMB_W];

    for (genvar k = 0; k < LIMB_W; k++) begin : g_row
        assign rows[k] = {{(LIMB_W-1){1'b0}}, x & {LIMB_W{y[k]}}} << k;
    end

    // addition over GF(2) without carries
    always_comb begin
        p = '0;
        for (int k = 0; k < LIMB_W; k++) begin
            p = p ^ rows[k];
        end
    end

endmodule

`default_nettype wire

//--- hw/limb_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module limb_scheduler #(
    parameter int LIMB_W = poly_mul_pkg::LIMB_W
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       start,
    input  wire poly_mul_pkg::operand_t     a,
    input  wire poly_mul_pkg::operand_t     b,
    output poly_mul_pkg::wb_req_t           wb,
    output poly_mul_pkg::product_rec_t      dat,
    input  wire logic                       ack,
    input  wire logic                       done,
    output logic                            busy
);

    localparam int NUM_LIMBS = poly_mul_pkg::NUM_LIMBS;
    localparam int POS_W     = poly_mul_pkg::POS_W;
    localparam int IDX_W     = $clog2(NUM_LIMBS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_LIMBS - 1);

    logic [NUM_LIMBS-1:0][LIMB_W-1:0] a_limbs;
    logic [NUM_LIMBS-1:0][LIMB_W-1:0] b_limbs;
    logic [IDX_W-1:0]    i;
    logic [IDX_W-1:0]    j;
    logic                running;
    logic                issued_all;
    logic                req;
    logic                load_rec;
    logic [2*LIMB_W-2:0] limb_prod;

    clmul_limb #(.LIMB_W(LIMB_W)) mul_i (
        .x (a_limbs[i]),
        .y (b_limbs[j]),
        .p (limb_prod)
    );

    // drops as soon as the last record has landed in the result
    assign busy     = running & ~(issued_all & done);
    assign load_rec = busy & ~req & ~issued_all;
    assign wb       = '{cyc: req, stb: req, we: 1'b1};

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            a_limbs <= a;
            b_limbs <= b;
        end
        if (load_rec) begin
            dat.prod  <= limb_prod;
            dat.pos   <= POS_W'(i) + POS_W'(j);
            dat.first <= (i == '0) && (j == '0);
            dat.last  <= (i == LAST_IDX) && (j == LAST_IDX);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running    <= 1'b0;
            issued_all <= 1'b0;
            req        <= 1'b0;
            i          <= '0;
            j          <= '0;
        end else if (!busy) begin
            running <= start;
            if (start) begin
                issued_all <= 1'b0;
                i          <= '0;
                j          <= '0;
            end
        end else if (req) begin
            // hold the record until the fifo takes it
            if (ack) begin
                req <= 1'b0;
                if (j == LAST_IDX) begin
                    j <= '0;
                    i <= i + 1'b1;
                    if (i == LAST_IDX) begin
                        issued_all <= 1'b1;
                    end
                end else begin
                    j <= j + 1'b1;
                end
            end
        end else if (!issued_all) begin
            req <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/poly_mul_pkg.sv
`default_nettype none

package poly_mul_pkg;

    // limb geometry of one 284-bit operand
    localparam int LIMB_W    = 71;
    localparam int NUM_LIMBS = 4;

    // limb offset of a product as i+j from 0 to 6
    localparam int POS_W = 3;

    // most significant limb first
    typedef struct packed {
        logic [LIMB_W-1:0] limb3;
        logic [LIMB_W-1:0] limb2;
        logic [LIMB_W-1:0] limb1;
        logic [LIMB_W-1:0] limb0;
    } operand_t;

    typedef struct packed {
        logic [2*LIMB_W-2:0] prod;
        logic [POS_W-1:0]    pos;
        logic                first;
        logic                last;
    } product_rec_t;

    // wishbone classic request from a master
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
    } wb_req_t;

endpackage

`default_nettype wire

//--- hw/poly_mul_top.sv
`timescale 1ns/1ns
`default_nettype none

module poly_mul_top #(
    parameter int LIMB_W     = poly_mul_pkg::LIMB_W,
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire poly_mul_pkg::operand_t a,
    input  wire poly_mul_pkg::operand_t b,
    output logic [8*LIMB_W-1:0]         product,
    output logic                        busy,
    output logic                        done
);

    poly_mul_pkg::wb_req_t      wr_wb;
    poly_mul_pkg::wb_req_t      rd_wb;
    poly_mul_pkg::product_rec_t wr_dat;
    poly_mul_pkg::product_rec_t rd_dat;
    logic                       wr_ack;
    logic                       rd_ack;
    logic                       acc_done;

    limb_scheduler #(.LIMB_W(LIMB_W)) sched_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .a     (a),
        .b     (b),
        .wb    (wr_wb),
        .dat   (wr_dat),
        .ack   (wr_ack),
        .done  (acc_done),
        .busy  (busy)
    );

    product_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .clk    (clk),
        .reset  (reset),
        .wr_wb  (wr_wb),
        .wr_dat (wr_dat),
        .wr_ack (wr_ack),
        .rd_wb  (rd_wb),
        .rd_dat (rd_dat),
        .rd_ack (rd_ack)
    );

    product_accumulator #(.LIMB_W(LIMB_W)) acc_i (
        .clk     (clk),
        .reset   (reset),
        .wb      (rd_wb),
        .dat     (rd_dat),
        .ack     (rd_ack),
        .product (product),
        .done    (acc_done)
    );

    // old result stays flagged until the first new record, so mask it while busy
    assign done = acc_done & ~busy;

endmodule

`default_nettype wire

//--- hw/product_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module product_accumulator #(
    parameter int LIMB_W = poly_mul_pkg::LIMB_W
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    output poly_mul_pkg::wb_req_t           wb,
    input  wire poly_mul_pkg::product_rec_t dat,
    input  wire logic                       ack,
    output logic [8*LIMB_W-1:0]             product,
    output logic                            done
);

    localparam int RES_W  = 8 * LIMB_W;
    localparam int PROD_W = 2 * LIMB_W - 1;

    logic             req;
    logic [RES_W-1:0] shifted;

    // limb product moved up by pos whole limbs
    assign shifted = {{(RES_W-PROD_W){1'b0}}, dat.prod} << (LIMB_W * dat.pos);

    assign wb = '{cyc: req, stb: req, we: 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            req     <= 1'b0;
            product <= '0;
            done    <= 1'b0;
        end else begin
            // keep polling the fifo while ack paces the reads
            req <= 1'b1;
            if (ack) begin
                if (dat.first) begin
                    product <= shifted;
                end else begin
                    product <= product ^ shifted;
                end
                if (dat.last) begin
                    done <= 1'b1;
                end else if (dat.first) begin
                    done <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/product_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module product_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire poly_mul_pkg::wb_req_t      wr_wb,
    input  wire poly_mul_pkg::product_rec_t wr_dat,
    output logic                            wr_ack,
    input  wire poly_mul_pkg::wb_req_t      rd_wb,
    output poly_mul_pkg::product_rec_t      rd_dat,
    output logic                            rd_ack
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

    poly_mul_pkg::product_rec_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             wr_fire;
    logic             rd_fire;

    assign full  = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // ~ack keeps a held strobe from being taken twice
    assign wr_fire = wr_wb.cyc & wr_wb.stb & wr_wb.we & ~wr_ack & ~full;
    assign rd_fire = rd_wb.cyc & rd_wb.stb & ~rd_wb.we & ~rd_ack & ~empty;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_dat;
        end
        if (rd_fire) begin
            rd_dat <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_fire;
            rd_ack <= rd_fire;
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module poly_mul_tb -f all.f -o Vpoly_mul_tb
./obj_dir/Vpoly_mul_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- verif/poly_mul_tb_util.svh
`ifndef POLY_MUL_TB_UTIL_SVH
`define POLY_MUL_TB_UTIL_SVH

// fibonacci lfsr over x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per operand bit
task automatic random_operand(output logic [OP_W-1:0] v);
    for (int k = 0; k < OP_W; k++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v[k] = lfsr_state[0];
    end
endtask

// schoolbook product over GF(2) one bit pair at a time
function automatic logic [RES_W-1:0] clmul_ref(
    input logic [OP_W-1:0] x,
    input logic [OP_W-1:0] y
);
    logic [RES_W-1:0] r;
    r = '0;
    for (int m = 0; m < OP_W; m++) begin
        for (int n = 0; n < OP_W; n++) begin
            r[m+n] = r[m+n] ^ (x[m] & y[n]);
        end
    end
    return r;
endfunction

task automatic check(
    input string            what,
    input logic [RES_W-1:0] expected,
    input logic [RES_W-1:0] actual
);
    if (actual !== expected) begin
        $display("Error: test %s, %s: expected %h, actual %h",
                 cur_test, what, expected, actual);
        error_count = error_count + 1;
    end
endtask

`endif

//--- verif/poly_mul_tb.sv
`timescale 1ns/1ns
`default_nettype none

module poly_mul_tb;

    localparam int OP_W           = poly_mul_pkg::NUM_LIMBS * poly_mul_pkg::LIMB_W;
    localparam int RES_W          = 2 * OP_W;
    localparam int NUM_RANDOM     = 20;
    localparam int NUM_TESTS      = NUM_RANDOM + 7;
    localparam int TIMEOUT_CYCLES = 400;

    logic                   clk;
    logic                   reset;
    logic                   start;
    poly_mul_pkg::operand_t a_in;
    poly_mul_pkg::operand_t b_in;
    logic [RES_W-1:0]       product;
    logic                   busy;
    logic                   done;

    logic [RES_W-1:0] expected_q [$];
    logic [31:0]      lfsr_state = 32'h44c7a2af;
    logic             done_q = 1'b0;
    logic             aborted = 1'b0;
    int               completions = 0;
    int               launched = 0;
    int               error_count = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    string            cur_test = "reset";

    `include "poly_mul_tb_util.svh"

    poly_mul_top #(
        .LIMB_W     (poly_mul_pkg::LIMB_W),
        .FIFO_DEPTH (4)
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .a       (a_in),
        .b       (b_in),
        .product (product),
        .busy    (busy),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // each rising edge of done closes one multiplication
    always @(negedge clk) begin
        if (!reset && done && !done_q) begin
            completions = completions + 1;
            if (expected_q.size() == 0) begin
                $display("done rose in test %s with no multiplication outstanding", cur_test);
                error_count = error_count + 1;
            end else begin
                check("product", expected_q.pop_front(), product);
            end
        end
        done_q = done;
    end

    task automatic launch(input logic [OP_W-1:0] x, input logic [OP_W-1:0] y);
        a_in  = x;
        b_in  = y;
        start = 1'b1;
        expected_q.push_back(clmul_ref(x, y));
        launched = launched + 1;
        @(posedge clk);
        #2;
        start = 1'b0;
        // one cycle after an accepted start
        check("busy after start", RES_W'(1'b1), RES_W'(busy));
        check("done after start", '0, RES_W'(done));
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (completions < launched && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (completions < launched) begin
            $display("timeout in test %s, done did not rise within %0d cycles",
                     cur_test, TIMEOUT_CYCLES);
            aborted = 1'b1;
        end
    endtask

    task automatic multiply(input logic [OP_W-1:0] x, input logic [OP_W-1:0] y);
        if (!aborted) begin
            launch(x, y);
            wait_for_done();
        end
    endtask

    task automatic run_test(input int t);
        logic [OP_W-1:0] x;
        logic [OP_W-1:0] y;
        int              errors_before;
        errors_before = error_count;
        random_operand(x);
        random_operand(y);
        if (t >= 5 && t < 5 + NUM_RANDOM) begin
            cur_test = $sformatf("random_%02d", t - 5);
            multiply(x, y);
        end else begin
            case (t)
                0: begin
                    cur_test = "reset";
                    check("busy", '0, RES_W'(busy));
                    check("done", '0, RES_W'(done));
                    check("product", '0, product);
                end
                1: begin
                    cur_test = "zero_times_b";
                    multiply('0, y);
                end
                2: begin
                    cur_test = "one_times_b";
                    multiply(OP_W'(1), y);
                end
                3: begin
                    cur_test = "x283_squared";
                    x = '0;
                    x[OP_W-1] = 1'b1;
                    multiply(x, x);
                end
                4: begin
                    cur_test = "all_ones";
                    multiply('1, '1);
                end
                5 + NUM_RANDOM: begin
                    cur_test = "start_while_busy";
                    launch(x, y);
                    repeat (3) begin
                        @(posedge clk);
                        #2;
                    end
                    check("busy at extra start", RES_W'(1'b1), RES_W'(busy));
                    // new operands and a start that must be ignored
                    a_in  = ~x;
                    b_in  = ~y;
                    start = 1'b1;
                    @(posedge clk);
                    #2;
                    start = 1'b0;
                    wait_for_done();
                    for (int c = 0; c < 100 && completions == launched; c++) begin
                        @(posedge clk);
                        #2;
                    end
                    check("completions", RES_W'(launched), RES_W'(completions));
                    check("held product", clmul_ref(x, y), product);
                end
                default: begin
                    cur_test = "back_to_back";
                    for (int k = 0; k < 3; k++) begin
                        random_operand(x);
                        random_operand(y);
                        multiply(x, y);
                    end
                end
            endcase
        end
        tests_run = tests_run + 1;
        if (error_count == errors_before && !aborted) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: failed", cur_test);
            tests_failed = tests_failed + 1;
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        a_in  = '0;
        b_in  = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0 && !aborted) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
